/* src/aes_config.svh */
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Data path widths
`define AES_BLOCK_W 128
`define AES_WORD_W  32
`define AES_BYTE_W  8

// AES-128 only
`define AES_NR          10
`define AES_ROUND_CNT_W 4

// Mode codes, two bits wide
`define AES_MODE_ECB 2'd0
`define AES_MODE_CFB 2'd1
`define AES_MODE_CBC 2'd2
`define AES_MODE_CTR 2'd3

`endif

/* src/aes_pkg.sv */
`default_nettype none

`include "aes_config.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_W-1:0] aes_block_t;

    typedef logic [1:0] aes_mode_t;  // Holds one of the AES_MODE_* codes

    // One column, row 0 in the top byte
    typedef logic [0:3][`AES_BYTE_W-1:0] aes_col_t;

    // Flat view for key and data XOR, column view for ShiftRows and MixColumns
    typedef union packed {
        aes_block_t       flat;
        aes_col_t   [0:3] cols;  // Column 0 at the top bits
    } aes_state_u;

    typedef struct packed {
        aes_mode_t  mode;
        aes_block_t key;
        aes_block_t data;
        aes_block_t iv;  // IV or counter block
    } aes_req_t;

    // What the output stage still needs once the cipher runs
    typedef struct packed {
        aes_mode_t  mode;
        aes_block_t data;
    } aes_pass_t;

endpackage

`default_nettype wire

/* src/aes_sbox.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_sbox (
    input  wire logic [`AES_BYTE_W-1:0] in_byte,
    output logic      [`AES_BYTE_W-1:0] out_byte
);

    logic [0:15][`AES_BYTE_W-1:0] row;  // Table row picked by the high nibble

    // Forward substitution table, one row per high nibble
    always_comb begin
        case (in_byte[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
        endcase
    end

    assign out_byte = row[in_byte[3:0]];  // Low nibble selects the column

endmodule

`default_nettype wire

/* src/aes_round.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_round (
    input  wire aes_pkg::aes_state_u state_in,
    input  wire aes_pkg::aes_block_t round_key,
    input  wire logic                final_round,  // Skip MixColumns
    output aes_pkg::aes_state_u      state_out
);

    wire aes_pkg::aes_state_u sub_s;  // After SubBytes
    aes_pkg::aes_state_u      shift_s;
    aes_pkg::aes_state_u      mix_s;

    // Multiply by 2 in GF(2^8)
    function automatic logic [`AES_BYTE_W-1:0] xtime(input logic [`AES_BYTE_W-1:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // SubBytes, one lane per byte
    genvar i;
    for (i = 0; i < 16; i++) begin : g_lane
        aes_sbox sbox_i (
            .in_byte  (state_in.flat[i*`AES_BYTE_W +: `AES_BYTE_W]),
            .out_byte (sub_s.flat[i*`AES_BYTE_W +: `AES_BYTE_W])
        );
    end

    // Row r rotates left by r bytes
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_s.cols[c][r] = sub_s.cols[(c + r) % 4][r];
            end
        end
    end

    // Each output byte is 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                mix_s.cols[c][r] = xtime(shift_s.cols[c][r])
                                 ^ xtime(shift_s.cols[c][(r + 1) % 4])
                                 ^ shift_s.cols[c][(r + 1) % 4]
                                 ^ shift_s.cols[c][(r + 2) % 4]
                                 ^ shift_s.cols[c][(r + 3) % 4];
            end
        end
    end

    // AddRoundKey
    assign state_out.flat = (final_round ? shift_s.flat : mix_s.flat) ^ round_key;

endmodule

`default_nettype wire

/* src/aes_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_key_schedule (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                load,
    input  wire aes_pkg::aes_block_t key_in,
    input  wire logic                step,
    output aes_pkg::aes_block_t      round_key  // Key for the next round
);

    aes_pkg::aes_state_u          key_r;   // Key of the round just applied
    aes_pkg::aes_state_u          next_key;
    logic [`AES_BYTE_W-1:0]       rcon_r;
    logic [0:3][`AES_BYTE_W-1:0]  sub_w;   // SubWord(RotWord(w3))
    logic [`AES_WORD_W-1:0]       temp_w;

    // RotWord folded into the lane inputs
    genvar j;
    for (j = 0; j < 4; j++) begin : g_sub
        aes_sbox sbox_i (
            .in_byte  (key_r.cols[3][(j + 1) % 4]),
            .out_byte (sub_w[j])
        );
    end

    assign temp_w = sub_w ^ {rcon_r, 24'h000000};

    // Cascading column XORs
    assign next_key.cols[0] = key_r.cols[0] ^ temp_w;
    assign next_key.cols[1] = key_r.cols[1] ^ next_key.cols[0];
    assign next_key.cols[2] = key_r.cols[2] ^ next_key.cols[1];
    assign next_key.cols[3] = key_r.cols[3] ^ next_key.cols[2];

    assign round_key = next_key.flat;

    always_ff @(posedge clk) begin
        if (load) begin
            key_r.flat <= key_in;
        end else if (step) begin
            key_r <= next_key;
        end
    end

    // Round constant doubles in GF(2^8) per step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rcon_r <= 8'h01;
        end else if (load) begin
            rcon_r <= 8'h01;
        end else if (step) begin
            rcon_r <= {rcon_r[6:0], 1'b0} ^ (rcon_r[7] ? 8'h1b : 8'h00);
        end
    end

    // The core never restarts the schedule in the middle of a block
    a_no_step_on_load : assert property (
        @(posedge clk) disable iff (reset) !(load && step)
    );

endmodule

`default_nettype wire

/* src/aes_cipher_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_cipher_core (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                load,
    input  wire aes_pkg::aes_block_t block_in,
    input  wire aes_pkg::aes_block_t key,
    output logic                     finish,
    output aes_pkg::aes_block_t      block_out
);

    aes_pkg::aes_state_u          state_r;
    aes_pkg::aes_state_u          round_out;
    aes_pkg::aes_block_t          round_key;
    logic [`AES_ROUND_CNT_W-1:0]  round_cnt;  // Round applied at the next edge, 0 when idle
    logic                         running;
    logic                         final_round;

    assign running     = (round_cnt != '0);
    assign final_round = (round_cnt == `AES_NR);

    aes_key_schedule key_schedule_i (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .key_in    (key),
        .step      (running),  // One key per round
        .round_key (round_key)
    );

    aes_round round_i (
        .state_in    (state_r),
        .round_key   (round_key),
        .final_round (final_round),
        .state_out   (round_out)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            round_cnt <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= running && final_round;  // Last round lands this edge
            if (load) begin
                round_cnt <= `AES_ROUND_CNT_W'(1);
            end else if (final_round) begin
                round_cnt <= '0;
            end else if (running) begin
                round_cnt <= round_cnt + `AES_ROUND_CNT_W'(1);
            end
        end
    end

    // Initial AddRoundKey on load, then one round per clock
    always_ff @(posedge clk) begin
        if (load) begin
            state_r.flat <= block_in ^ key;
        end else if (running) begin
            state_r <= round_out;
        end
    end

    assign block_out = state_r.flat;

    a_round_cnt_range : assert property (
        @(posedge clk) disable iff (reset) round_cnt <= `AES_NR
    );

    // Input stage must hold off until the block has left the core
    a_no_load_while_running : assert property (
        @(posedge clk) disable iff (reset) load |-> !running
    );

endmodule

`default_nettype wire

/* src/aes_mode_in.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_mode_in (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,
    input  wire aes_pkg::aes_req_t   req,
    input  wire logic                done,
    output logic                     busy,
    output logic                     load,
    output aes_pkg::aes_block_t      block_out,
    output aes_pkg::aes_block_t      key,
    output aes_pkg::aes_pass_t       pass
);

    logic                accept;
    aes_pkg::aes_block_t cipher_in;

    assign accept = start && !busy;  // Start while busy is dropped

    // Block fed to the cipher
    always_comb begin
        case (req.mode)
            `AES_MODE_ECB: cipher_in = req.data;
            `AES_MODE_CBC: cipher_in = req.data ^ req.iv;
            default:       cipher_in = req.iv;  // CFB and CTR
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            load <= 1'b0;
        end else begin
            load <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            block_out <= cipher_in;
            key       <= req.key;
            pass.mode <= req.mode;
            pass.data <= req.data;
        end
    end

endmodule

`default_nettype wire

/* src/aes_mode_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_mode_out (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                finish,
    input  wire aes_pkg::aes_block_t block_in,
    input  wire aes_pkg::aes_pass_t  pass,
    output aes_pkg::aes_block_t      result,
    output logic                     done
);

    logic use_xor;

    // Stream modes mask the data with the cipher output
    assign use_xor = (pass.mode == `AES_MODE_CFB) || (pass.mode == `AES_MODE_CTR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                result <= use_xor ? (block_in ^ pass.data) : block_in;
            end
        end
    end

    // One block in flight, so done is always a single pulse
    a_done_pulse : assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    );

endmodule

`default_nettype wire

/* src/aes_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_top (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,
    input  wire aes_pkg::aes_req_t   req,
    output aes_pkg::aes_block_t      result,
    output logic                     done,
    output logic                     busy
);

    logic                load;
    logic                finish;
    aes_pkg::aes_block_t cipher_in;
    aes_pkg::aes_block_t cipher_key;
    aes_pkg::aes_block_t cipher_out;
    aes_pkg::aes_pass_t  pass;

    aes_mode_in mode_in_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .req       (req),
        .done      (done),
        .busy      (busy),
        .load      (load),
        .block_out (cipher_in),
        .key       (cipher_key),
        .pass      (pass)
    );

    aes_cipher_core cipher_core_i (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .block_in  (cipher_in),
        .key       (cipher_key),
        .finish    (finish),
        .block_out (cipher_out)
    );

    aes_mode_out mode_out_i (
        .clk      (clk),
        .reset    (reset),
        .finish   (finish),
        .block_in (cipher_out),
        .pass     (pass),
        .result   (result),
        .done     (done)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns = 40.0
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verif/aes_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_tb;

    localparam real clk_period = 40.0;
    localparam int  num_ops    = 166;  // Requests issued over the whole run

    logic                clk;
    logic                reset;
    logic                start;
    aes_pkg::aes_req_t   req;
    aes_pkg::aes_block_t result;
    logic                done;
    logic                busy;

    logic [31:0] lfsr;
    logic [7:0]  sbox_tab [256];  // Built from the field inverse at time 0
    int          value_errs;
    int          other_errs;

    tb_clock_gen #(.period_ns(clk_period)) clock_gen_i (.clk(clk));

    aes_top aes_top_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .req    (req),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p ^= a;
            a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Multiplicative inverse, then the affine transform
    function automatic logic [7:0] sbox_calc(input logic [7:0] x);
        logic [7:0] inv;
        logic [7:0] s;
        inv = 8'h00;
        for (int y = 1; y < 256; y++) begin
            if (gf_mul(x, 8'(y)) == 8'h01) inv = 8'(y);
        end
        s = inv ^ 8'h63;
        for (int k = 1; k < 5; k++) begin
            s ^= 8'({inv, inv} >> (8 - k));  // Rotate left by k
        end
        return s;
    endfunction

    function automatic aes_pkg::aes_block_t encrypt_model(input aes_pkg::aes_block_t key,
                                                          input aes_pkg::aes_block_t blk);
        logic [31:0]         w [44];
        logic [7:0]          s [16];
        logic [7:0]          t [16];
        logic [31:0]         temp;
        logic [7:0]          rcon;
        aes_pkg::aes_block_t out;
        rcon = 8'h01;
        for (int i = 0; i < 4; i++) w[i] = key[127 - 32*i -: 32];
        for (int i = 4; i < 44; i++) begin
            temp = w[i-1];
            if (i % 4 == 0) begin
                temp = {sbox_tab[temp[23:16]], sbox_tab[temp[15:8]],
                        sbox_tab[temp[7:0]], sbox_tab[temp[31:24]]} ^ {rcon, 24'h0};
                rcon = gf_mul(rcon, 8'h02);
            end
            w[i] = w[i-4] ^ temp;
        end
        // Byte i sits in row i%4 of column i/4
        for (int i = 0; i < 16; i++) s[i] = blk[127 - 8*i -: 8] ^ w[i/4][31 - 8*(i%4) -: 8];
        for (int rnd = 1; rnd <= `AES_NR; rnd++) begin
            for (int i = 0; i < 16; i++) t[i] = sbox_tab[s[(i + 4*(i%4)) % 16]];
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    s[4*c+r] = (rnd == `AES_NR) ? t[4*c+r]
                             : gf_mul(t[4*c+r], 8'h02) ^ gf_mul(t[4*c+(r+1)%4], 8'h03)
                               ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
                    s[4*c+r] ^= w[4*rnd+c][31 - 8*r -: 8];
                end
            end
        end
        for (int i = 0; i < 16; i++) out[127 - 8*i -: 8] = s[i];
        return out;
    endfunction

    function automatic aes_pkg::aes_block_t mode_model(input aes_pkg::aes_req_t r);
        case (r.mode)
            `AES_MODE_ECB: return encrypt_model(r.key, r.data);
            `AES_MODE_CBC: return encrypt_model(r.key, r.data ^ r.iv);
            default:       return encrypt_model(r.key, r.iv) ^ r.data;  // CFB, CTR
        endcase
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic aes_pkg::aes_block_t rand_bits(input int n);
        aes_pkg::aes_block_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[126:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);  // One step per bit
        end
        return v;
    endfunction

    function automatic aes_pkg::aes_req_t rand_req(input aes_pkg::aes_mode_t mode);
        aes_pkg::aes_req_t r;
        r.mode = mode;
        r.key  = rand_bits(128);
        r.data = rand_bits(128);
        r.iv   = rand_bits(128);
        return r;
    endfunction

    task automatic check_block(input string name, input aes_pkg::aes_block_t exp,
                               input aes_pkg::aes_block_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    // Start high for one edge, returns 2 ns after the start edge
    task automatic send_req(input aes_pkg::aes_req_t r);
        start = 1'b1;
        req   = r;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_done(input string name, output bit seen);
        int n;
        n = 0;
        while (!done && n < 20) begin
            @(posedge clk);
            #2;
            n++;
        end
        seen = done;
        if (!seen) begin
            other_errs++;
            $display("%s: done did not arrive within 20 cycles", name);
        end
    endtask

    task automatic run_block(input string name, input aes_pkg::aes_req_t r);
        bit seen;
        send_req(r);
        wait_done(name, seen);
        if (seen) check_block(name, mode_model(r), result);
        @(posedge clk);  // Let busy fall
        #2;
    endtask

    initial begin
        #(num_ops * 16 * clk_period + 2000.0);
        $display("Timeout: the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        aes_pkg::aes_req_t  r;
        aes_pkg::aes_req_t  r2;
        aes_pkg::aes_mode_t modes [3];
        bit                 seen;
        modes      = '{`AES_MODE_CBC, `AES_MODE_CFB, `AES_MODE_CTR};
        lfsr       = 32'hf30c;
        value_errs = 0;
        other_errs = 0;
        reset      = 1'b1;
        start      = 1'b0;
        req        = '0;
        for (int i = 0; i < 256; i++) sbox_tab[i] = sbox_calc(8'(i));
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // Known answer, FIPS-197 appendix C.1
        r.mode = `AES_MODE_ECB;
        r.key  = 128'h000102030405060708090a0b0c0d0e0f;
        r.data = 128'h00112233445566778899aabbccddeeff;
        r.iv   = '0;
        if (mode_model(r) !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
            other_errs++;
            $display("Reference model disagrees with the known answer");
        end
        send_req(r);
        wait_done("ecb known answer", seen);
        if (seen) check_block("ecb known answer", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, result);
        @(posedge clk);
        #2;

        for (int i = 0; i < 40; i++) begin
            run_block($sformatf("random ecb %0d", i), rand_req(`AES_MODE_ECB));
        end
        foreach (modes[m]) begin
            for (int i = 0; i < 40; i++) begin
                run_block($sformatf("random mode %0d block %0d", modes[m], i),
                          rand_req(modes[m]));
            end
        end

        // Cycle by cycle view of done and busy
        r = rand_req(`AES_MODE_CTR);
        send_req(r);
        check_bit("latency busy at cycle 0", 1'b1, busy);
        for (int k = 1; k <= 13; k++) begin
            @(posedge clk);
            #2;
            check_bit($sformatf("latency done at cycle %0d", k), k == 12, done);
            check_bit($sformatf("latency busy at cycle %0d", k), k <= 12, busy);
            if (k == 12) check_block("latency result", mode_model(r), result);
        end

        // Second start lands mid-block
        r  = rand_req(`AES_MODE_CBC);
        r2 = rand_req(`AES_MODE_ECB);
        send_req(r);
        repeat (4) @(posedge clk);
        #2;
        send_req(r2);
        wait_done("start while busy", seen);
        if (seen) check_block("start while busy", mode_model(r), result);
        for (int k = 0; k < 20; k++) begin
            @(posedge clk);
            #2;
            check_bit("start while busy second done", 1'b0, done);
        end

        // Abandon a block with reset
        send_req(rand_req(`AES_MODE_CFB));
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b1;
        #5;
        check_bit("reset mid-block busy", 1'b0, busy);
        @(posedge clk);
        #2;
        reset = 1'b0;
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            #2;
            check_bit("reset mid-block late done", 1'b0, done);
        end
        check_block("reset mid-block result", '0, result);
        run_block("reset follow-up", rand_req(`AES_MODE_CBC));

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_round.sv
src/aes_key_schedule.sv
src/aes_cipher_core.sv
src/aes_mode_in.sv
src/aes_mode_out.sv
src/aes_top.sv
verif/tb_clock_gen.sv
verif/aes_tb.sv
